/* source/spinn_rx_pkg.sv */
// shared definitions for the SpiNNaker link receiver
// packet layout, decoded symbol struct and the NRZ 2-of-7 code table
// imported by every receiver module
package spinn_rx_pkg;

  // --------------------
  // sizes
  localparam int pkt_bits     = 72;  // long packet
  localparam int short_bits   = 40;  // short packet, ctrl + key
  localparam int payload_bits = 32;
  localparam int short_syms   = 10;  // data symbols per short packet
  localparam int long_syms    = 18;  // data symbols per long packet

  typedef logic [4:0] sym_cnt_t;  // holds up to long_syms

  localparam logic [6:0] eop_code = 7'b1100000;  // wires 5 and 6 change

  // --------------------
  // packet word, first nibble ends up in ctrl[3:0]
  typedef struct packed {
    logic [payload_bits-1:0] payload;  // zero on short packets
    logic [31:0]             key;
    logic [7:0]              ctrl;     // bit 1 set on long packets
  } pkt_t;

  // one line change, classified
  typedef struct packed {
    logic       nsb;    // complete symbol on the line
    logic       dat;    // data nibble
    logic       eop;    // end-of-packet
    logic       bad;    // illegal code
    logic [3:0] value;  // nibble, zero unless dat
  } symbol_t;

  // --------------------
  // chg is new line state xor previous line state
  function automatic symbol_t decode_2of7(input logic [6:0] chg);
    symbol_t s;
    s     = '0;
    s.nsb = 1'b1;
    s.dat = 1'b1;  // cleared below if not a data code
    case (chg)
      7'b0010001: s.value = 4'd0;
      7'b0010010: s.value = 4'd1;
      7'b0010100: s.value = 4'd2;
      7'b0011000: s.value = 4'd3;
      7'b0100001: s.value = 4'd4;
      7'b0100010: s.value = 4'd5;
      7'b0100100: s.value = 4'd6;
      7'b0101000: s.value = 4'd7;
      7'b1000001: s.value = 4'd8;
      7'b1000010: s.value = 4'd9;
      7'b1000100: s.value = 4'd10;
      7'b1001000: s.value = 4'd11;
      7'b0000011: s.value = 4'd12;
      7'b0000110: s.value = 4'd13;
      7'b0001100: s.value = 4'd14;
      7'b0001001: s.value = 4'd15;
      eop_code: begin
        s.dat = 1'b0;
        s.eop = 1'b1;
      end
      // nothing or a single wire so far, symbol still in flight
      7'b0000000, 7'b0000001, 7'b0000010, 7'b0000100,
      7'b0001000, 7'b0010000, 7'b0100000, 7'b1000000: begin
        s.nsb = 1'b0;
        s.dat = 1'b0;
      end
      default: begin  // three or more wires, or a wrong pair
        s.dat = 1'b0;
        s.bad = 1'b1;
      end
    endcase
    return s;
  endfunction

endpackage

/* source/nrz_2of7_decoder.sv */
// NRZ 2-of-7 line decoder for the SpiNNaker link
// keeps the last acknowledged line state and the ack toggle,
// and classifies the current change on the line as a symbol
// the framing FSM consumes a symbol with the take strobe
`timescale 1ns/100ps

module nrz_2of7_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [6:0]           data_2of7,  // raw link wires
  input  logic                 take,       // consume symbol, toggle ack
  output logic                 ack,
  output spinn_rx_pkg::symbol_t sym
);
  import spinn_rx_pkg::*;

  logic [6:0] old_data;  // line state at the last ack
  logic       start;     // first cycle out of reset

  // --------------------
  // start-up and ack
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start <= 1'b1;
      ack   <= 1'b0;
    end else begin
      start <= 1'b0;
      if (start)
        ack <= 1'b1;  // link idles with ack high
      else if (take)
        ack <= ~ack;  // one toggle per symbol
    end
  end

  // line state snapshot, primed by start
  always_ff @(posedge clk) begin
    if (start || take)
      old_data <= data_2of7;
  end

  // --------------------
  // symbol classification
  always_comb begin
    if (start)
      sym = '0;  // old_data not captured yet
    else
      sym = decode_2of7(data_2of7 ^ old_data);
  end

  // the FSM must not consume anything before the line is primed
  a_no_take_at_start: assert property (
    @(posedge clk) disable iff (rst) start |-> !take
  ) else $error("take raised during decoder start-up");

endmodule

/* source/rx_frame_fsm.sv */
// packet framing FSM for the SpiNNaker link receiver
// counts data symbols, latches the packet length from the first nibble
// and checks the count on end-of-packet; misframed packets are dropped
// bad symbols set a sticky err and park the FSM until end-of-packet
`timescale 1ns/100ps

module rx_frame_fsm #(
  parameter int err_timeout = 31  // idle cycles in error state before a forced ack
) (
  input  logic                  clk,
  input  logic                  rst,
  input  spinn_rx_pkg::symbol_t sym,
  input  logic                  busy,      // output register stalled
  output logic                  take,      // ack the current symbol
  output logic                  shift,     // data nibble into the packet
  output logic                  deliver,   // framed packet to output
  output logic                  long_pkt,  // length of current packet
  output logic                  err        // sticky, cleared by reset
);
  import spinn_rx_pkg::*;

  localparam int tmo_bits = $clog2(err_timeout + 1);

  typedef enum logic [2:0] {
    idle_s,  // waiting for first nibble
    pkt_s,   // collecting nibbles
    eop_s,   // eop seen, length check
    wait_s,  // good packet, output busy
    err_s    // bad symbol, resync on eop
  } state_t;

  state_t              state;
  state_t              next;
  sym_cnt_t            sym_cnt;  // data symbols so far
  logic                exp_eop;  // count matches length
  logic [tmo_bits-1:0] err_cnt;
  logic                tmo;      // error timeout expired

  assign exp_eop = long_pkt ? (sym_cnt == sym_cnt_t'(long_syms))
                            : (sym_cnt == sym_cnt_t'(short_syms));
  assign tmo     = (err_cnt == '0);

  // --------------------
  // next state and strobes
  always_comb begin
    next    = state;
    take    = 1'b0;
    shift   = 1'b0;
    deliver = 1'b0;
    case (state)
      idle_s: begin
        take  = sym.nsb;  // stray eop or bad also acked
        shift = sym.dat;
        if (sym.dat)
          next = pkt_s;
        else if (sym.bad)
          next = err_s;
      end
      pkt_s: begin
        take  = sym.dat || sym.bad;  // eop waits for the check
        shift = sym.dat;
        if (sym.bad)
          next = err_s;
        else if (sym.eop)
          next = eop_s;
      end
      eop_s: begin
        take    = !busy;  // eop ack held back while stalled
        deliver = exp_eop && !busy;
        if (!busy)
          next = idle_s;  // delivered or dropped quietly
        else if (exp_eop)
          next = wait_s;
      end
      wait_s: begin
        take    = !busy;
        deliver = !busy;
        if (!busy)
          next = idle_s;
      end
      err_s: begin
        take = sym.nsb || tmo;  // ack anyway so a stuck link recovers
        if (sym.eop)
          next = idle_s;
      end
      default: next = idle_s;
    endcase
  end

  // --------------------
  // state registers
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      state <= idle_s;
    else
      state <= next;
  end

  // symbol count and length
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sym_cnt  <= '0;
      long_pkt <= 1'b0;
    end else if (state == idle_s) begin
      sym_cnt <= sym.dat ? sym_cnt_t'(1) : '0;
      if (sym.dat)
        long_pkt <= sym.value[1];  // ctrl bit 1
    end else if (state == pkt_s && sym.dat) begin
      sym_cnt <= sym_cnt + 1'b1;
    end
  end

  // sticky error flag
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      err <= 1'b0;
    else if (next == err_s)
      err <= 1'b1;
  end

  // error timeout, restarts on every symbol
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      err_cnt <= tmo_bits'(err_timeout);
    else if (state != err_s || sym.nsb || tmo)
      err_cnt <= tmo_bits'(err_timeout);
    else
      err_cnt <= err_cnt - 1'b1;
  end

  // a packet goes out only to a free output register,
  // while its end-of-packet is still unacked on the line
  a_no_deliver_busy: assert property (
    @(posedge clk) disable iff (rst) deliver |-> (sym.eop && !busy)
  ) else $error("deliver while output busy or without end-of-packet");

endmodule

/* source/pkt_assembler.sv */
// packet assembly for the SpiNNaker link receiver
// shifts nibbles into a 72-bit buffer, aligns short packets down
// and holds the result in a valid/ready output register
`timescale 1ns/100ps

module pkt_assembler (
  input  logic                  clk,
  input  logic                  rst,
  input  spinn_rx_pkg::symbol_t sym,
  input  logic                  shift,     // take sym.value
  input  logic                  deliver,   // load output register
  input  logic                  long_pkt,
  output logic                  busy,      // output stalled
  output spinn_rx_pkg::pkt_t    pkt_data,
  output logic                  pkt_vld,
  input  logic                  pkt_rdy
);
  import spinn_rx_pkg::*;

  logic [pkt_bits-1:0] nib_buf;  // newest nibble at the top
  pkt_t                nxt_pkt;

  // --------------------
  // nibble shift register
  always_ff @(posedge clk) begin
    if (shift)
      nib_buf <= {sym.value, nib_buf[pkt_bits-1:4]};
  end

  // short packet sits in the top 40 bits after 10 shifts
  always_comb begin
    if (long_pkt)
      nxt_pkt = nib_buf;
    else
      nxt_pkt = {{payload_bits{1'b0}}, nib_buf[pkt_bits-1 -: short_bits]};
  end

  // --------------------
  // output register
  always_ff @(posedge clk) begin
    if (deliver)
      pkt_data <= nxt_pkt;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      pkt_vld <= 1'b0;
    else if (deliver)
      pkt_vld <= 1'b1;
    else if (pkt_rdy)
      pkt_vld <= 1'b0;  // transfer done
  end

  assign busy = pkt_vld && !pkt_rdy;

  // a stalled packet must not change under the consumer
  a_hold_stalled: assert property (
    @(posedge clk) disable iff (rst)
    (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt_data))
  ) else $error("pkt_data changed while stalled");

endmodule

/* source/spinn_receiver.sv */
// SpiNNaker link receiver, top level
// 2-of-7 NRZ link in with toggling ack, 72-bit packets out on valid/ready
// err_timeout sets the forced-ack delay in the error state
`timescale 1ns/100ps

module spinn_receiver #(
  parameter int err_timeout = 31
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [6:0]         data_2of7,
  output logic               ack,
  output spinn_rx_pkg::pkt_t pkt_data,
  output logic               pkt_vld,
  input  logic               pkt_rdy,
  output logic               err
);
  import spinn_rx_pkg::*;

  symbol_t sym;       // current line change
  logic    take;
  logic    shift;
  logic    deliver;
  logic    long_pkt;
  logic    busy;

  // --------------------
  nrz_2of7_decoder i_nrz_2of7_decoder (
    .clk       (clk),
    .rst       (rst),
    .data_2of7 (data_2of7),
    .take      (take),
    .ack       (ack),
    .sym       (sym)
  );

  rx_frame_fsm #(
    .err_timeout (err_timeout)
  ) i_rx_frame_fsm (
    .clk      (clk),
    .rst      (rst),
    .sym      (sym),
    .busy     (busy),
    .take     (take),
    .shift    (shift),
    .deliver  (deliver),
    .long_pkt (long_pkt),
    .err      (err)
  );

  pkt_assembler i_pkt_assembler (
    .clk      (clk),
    .rst      (rst),
    .sym      (sym),
    .shift    (shift),
    .deliver  (deliver),
    .long_pkt (long_pkt),
    .busy     (busy),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy)
  );

endmodule

/* test/tb_spinn_receiver.sv */
// testbench for the SpiNNaker link receiver
// models the 2-of-7 NRZ transmitter, collects packets off the valid/ready port
// and runs directed tests for framing, back-pressure and bad symbols
`timescale 1ns/100ps

module tb_spinn_receiver;

  // --------------------
  // link constants and limits
  localparam int sym_bound  = 8;    // cycles allowed for one ack toggle
  localparam int total_syms = 111;  // symbols sent over all tests
  localparam int max_cycles = total_syms * sym_bound + 400;  // slack for settle waits
  localparam logic [6:0] eop_sym = 7'h60;  // wires 5 and 6
  localparam logic [6:0] bad_sym = 7'h07;  // three wires at once
  // data codes, indexed by nibble
  localparam logic [6:0] nib_code [16] = '{
    7'h11, 7'h12, 7'h14, 7'h18, 7'h21, 7'h22, 7'h24, 7'h28,
    7'h41, 7'h42, 7'h44, 7'h48, 7'h03, 7'h06, 7'h0c, 7'h09
  };

  logic        clk;
  logic        rst;
  logic [6:0]  data_2of7;
  logic        ack;
  logic [71:0] pkt_data;
  logic        pkt_vld;
  logic        pkt_rdy;
  logic        err;

  logic [71:0] got [$];  // packets taken off the output, in order
  int          errors;
  int          failed;
  int          cycles;

  spinn_receiver #(.err_timeout(31)) i_spinn_receiver (
    .clk       (clk),
    .rst       (rst),
    .data_2of7 (data_2of7),
    .ack       (ack),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .err       (err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // consumer side, transfer happens on the next rising edge
  always @(negedge clk) begin
    if (pkt_vld && pkt_rdy)
      got.push_back(pkt_data);
  end

  // hung-run guard
  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run stopped after %0d cycles", cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------
  // helpers
  task automatic report_mismatch(input string test, input logic [71:0] exp,
                                 input logic [71:0] act);
    $display("MISMATCH %s: expected %h, actual %h", test, exp, act);
    errors++;
  endtask

  // bounded wait for ack to move away from prev
  task automatic wait_ack(input string test, input logic prev);
    int n;
    n = 0;
    while (ack == prev && n < sym_bound) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ack == prev) begin
      $display("%s: ack did not toggle within %0d cycles", test, sym_bound);
      errors++;
    end
  endtask

  task automatic send_sym(input string test, input logic [6:0] code);
    logic prev;
    prev      = ack;
    data_2of7 = data_2of7 ^ code;  // NRZ, changed wires toggle
    wait_ack(test, prev);
  endtask

  // random nibbles, header first; exp gets nibble i at bits 4i+3..4i
  task automatic send_nibs(input string test, input int nsyms, input logic long_hdr,
                           output logic [71:0] exp);
    logic [3:0] nib;
    int         i;
    exp = '0;
    for (i = 0; i < nsyms; i++) begin
      nib = 4'($urandom());
      if (i == 0)
        nib[1] = long_hdr;  // ctrl bit 1 picks the length
      if (i < 18)
        exp[4*i +: 4] = nib;
      send_sym(test, nib_code[nib]);
    end
  endtask

  // wait for count packets, then a few cycles more to catch extras
  task automatic wait_pkts(input string test, input int count);
    int n;
    n = 0;
    while (got.size() < count && n < 4 * sym_bound) begin
      @(posedge clk);
      #1;
      n++;
    end
    repeat (4) @(posedge clk);
    #1;
    if (got.size() != count)
      report_mismatch({test, " packet count"}, count, got.size());
  endtask

  task automatic finish_test(input string test, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", test);
    end else begin
      $display("test %s: failed", test);
      failed++;
    end
  endtask

  // --------------------
  // directed tests
  task automatic test_reset();
    int e0;
    e0 = errors;
    if (ack !== 1'b1)
      report_mismatch("reset ack", 1, ack);
    if (pkt_vld !== 1'b0)
      report_mismatch("reset pkt_vld", 0, pkt_vld);
    if (err !== 1'b0)
      report_mismatch("reset err", 0, err);
    finish_test("reset", e0);
  endtask

  // one good packet of nsyms nibbles, compared against the nibble order
  task automatic test_packet(input string test, input int nsyms, input logic long_hdr);
    logic [71:0] exp;
    int          e0;
    e0 = errors;
    got.delete();
    send_nibs(test, nsyms, long_hdr, exp);
    send_sym(test, eop_sym);
    wait_pkts(test, 1);
    if (got.size() == 1 && got[0] !== exp)
      report_mismatch(test, exp, got[0]);
    if (err !== 1'b0)
      report_mismatch({test, " err"}, 0, err);
    finish_test(test, e0);
  endtask

  task automatic test_backpressure();
    logic [71:0] exp_a;
    logic [71:0] exp_b;
    logic        prev;
    int          e0;
    e0 = errors;
    got.delete();
    pkt_rdy = 1'b0;
    send_nibs("backpressure", 10, 1'b0, exp_a);
    send_sym("backpressure", eop_sym);  // delivered, now stalled
    if (pkt_vld !== 1'b1)
      report_mismatch("backpressure pkt_vld", 1, pkt_vld);
    send_nibs("backpressure", 10, 1'b0, exp_b);
    prev      = ack;
    data_2of7 = data_2of7 ^ eop_sym;  // its ack must be held back
    repeat (6) begin
      @(posedge clk);
      #1;
      if (ack !== prev) begin
        $display("backpressure: end-of-packet acked while output stalled");
        errors++;
      end
      if (pkt_data !== exp_a)
        report_mismatch("backpressure hold", exp_a, pkt_data);
    end
    pkt_rdy = 1'b1;
    wait_ack("backpressure", prev);
    wait_pkts("backpressure", 2);
    if (got.size() == 2) begin
      if (got[0] !== exp_a)
        report_mismatch("backpressure first", exp_a, got[0]);
      if (got[1] !== exp_b)
        report_mismatch("backpressure second", exp_b, got[1]);
    end
    finish_test("backpressure", e0);
  endtask

  task automatic test_framing();
    logic [71:0] exp;
    int          e0;
    e0 = errors;
    got.delete();
    send_nibs("framing", 8, 1'b0, exp);  // short header, two nibbles short
    send_sym("framing", eop_sym);
    wait_pkts("framing", 0);             // dropped quietly
    send_nibs("framing", 18, 1'b0, exp);  // short header, long packet length
    send_sym("framing", eop_sym);
    wait_pkts("framing", 0);
    if (err !== 1'b0)
      report_mismatch("framing err", 0, err);
    send_nibs("framing", 10, 1'b0, exp);
    send_sym("framing", eop_sym);
    wait_pkts("framing", 1);
    if (got.size() == 1 && got[0] !== exp)
      report_mismatch("framing", exp, got[0]);
    finish_test("framing", e0);
  endtask

  task automatic test_bad_symbol();
    logic [71:0] exp;
    int          e0;
    e0 = errors;
    got.delete();
    send_nibs("bad symbol", 4, 1'b1, exp);
    send_sym("bad symbol", bad_sym);
    if (err !== 1'b1)
      report_mismatch("bad symbol err", 1, err);
    send_nibs("bad symbol", 3, 1'b0, exp);  // ignored until resync
    send_sym("bad symbol", eop_sym);
    wait_pkts("bad symbol", 0);
    send_nibs("bad symbol", 10, 1'b0, exp);
    send_sym("bad symbol", eop_sym);
    wait_pkts("bad symbol", 1);
    if (got.size() == 1 && got[0] !== exp)
      report_mismatch("bad symbol", exp, got[0]);
    if (err !== 1'b1)
      report_mismatch("bad symbol sticky err", 1, err);
    finish_test("bad symbol", e0);
  endtask

  // --------------------
  // main sequence
  initial begin
    errors    = 0;
    failed    = 0;
    rst       = 1'b1;
    data_2of7 = '0;
    pkt_rdy   = 1'b1;
    void'($urandom(32'h3349_0aa6));  // seeds the generator once
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);  // decoder primes ack and line state
    #1;
    test_reset();
    test_packet("short", 10, 1'b0);
    test_packet("long", 18, 1'b1);
    test_backpressure();
    test_framing();
    test_bad_symbol();  // last, err stays set
    $display("tests 6, failed %0d, errors %0d", failed, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
source/spinn_rx_pkg.sv
source/nrz_2of7_decoder.sv
source/rx_frame_fsm.sv
source/pkt_assembler.sv
source/spinn_receiver.sv
test/tb_spinn_receiver.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_spinn_receiver
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_EXE   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_EXE) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
